// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fdc
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulator output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
fdc_pkg.sv
ff40_ctrl_reg.sv
wd_access_stretch.sv
drive_mount_status.sv
host_response.sv
fdc.sv
fdc_properties.sv
tb_fdc.sv

// ==== drive_mount_status.sv ====
// Per-drive mount tracking, gives each core its write protect, ready, layout and side
`timescale 1ns/1ps

module drive_mount_status
(
	input	logic				CLK,
	input	logic				RESET_N,
	input	logic [fdc_pkg::NUM_DRIVES-1:0]	img_mounted,	// Pulses high per drive on mount
	input	logic				img_readonly,
	input	logic [63:0]			img_size,	// Image size in bytes
	input	fdc_pkg::ff40_reg_t		ff40,
	output	fdc_pkg::drive_cfg_t		drive_cfg [fdc_pkg::NUM_DRIVES]
);

	import fdc_pkg::*;

	logic [NUM_DRIVES-1:0]	mnt_d;		// Previous mount level
	logic [NUM_DRIVES-1:0]	mnt_fall;	// Mount pulse ending
	logic [NUM_DRIVES-1:0]	wp, ready, dbl;
	logic			in_window;

	assign mnt_fall = mnt_d & ~img_mounted;
	assign in_window = (img_size > DS_MIN_BYTES) && (img_size < DS_MAX_BYTES);

	always_ff @(posedge CLK)
	begin
		if (!RESET_N)
		begin
			mnt_d <= '0;
			wp <= '0;
			ready <= '0;
			dbl <= '0;
		end
		else
		begin
			mnt_d <= img_mounted;
			for (int i = 0; i < NUM_DRIVES; i++)
			begin
				if (mnt_fall[i])
				begin
					wp[i] <= img_readonly;
					ready[i] <= 1'b1;
					dbl[i] <= in_window && (i != NUM_DRIVES - 1);	// Last drive is SS only
				end
			end
		end
	end

	// Double-sided images use track-side-sector order
	always_comb
	begin
		for (int i = 0; i < NUM_DRIVES; i++)
			drive_cfg[i] = '{wp: wp[i], ready: ready[i], layout: !dbl[i],
				side: dbl[i] && ff40.side_sel};
	end

endmodule

// ==== fdc.sv ====
// Floppy controller glue top level, placed between the CPU bus and the four controller cores
`timescale 1ns/1ps

module fdc
(
	input	logic					CLK,
	input	logic					RESET_N,

	// CPU bus
	input	logic [3:0]				addr,
	input	logic [7:0]				data_in,
	input	logic					hdd_en,
	input	logic					ff40_wr,
	input	logic					wd_rd_ctrl,
	input	logic					wd_wr_ctrl,

	// Image mount events
	input	logic [fdc_pkg::NUM_DRIVES-1:0]		img_mounted,
	input	logic					img_readonly,
	input	logic [63:0]				img_size,

	// From the cores
	input	fdc_pkg::drive_resp_t			drive_resp [fdc_pkg::NUM_DRIVES],

	// To the CPU
	output	logic [7:0]				data_hdd,
	output	logic					halt,
	output	logic					nmi,

	// To the cores
	output	logic					core_ce,
	output	logic [fdc_pkg::NUM_DRIVES-1:0]		drive_rd,
	output	logic [fdc_pkg::NUM_DRIVES-1:0]		drive_wr,
	output	fdc_pkg::wd_access_t			wd_access,
	output	fdc_pkg::drive_cfg_t			drive_cfg [fdc_pkg::NUM_DRIVES]
);

	import fdc_pkg::*;

	ff40_reg_t	ff40;
	drive_idx_t	drive_idx;
	logic		sel_intrq;

	ff40_ctrl_reg u_ctrl
	(
		.CLK		(CLK),
		.RESET_N	(RESET_N),
		.ff40_wr	(ff40_wr),
		.data_in	(data_in),
		.sel_intrq	(sel_intrq),
		.ff40		(ff40),
		.drive_idx	(drive_idx)
	);

	wd_access_stretch u_stretch
	(
		.CLK		(CLK),
		.RESET_N	(RESET_N),
		.addr		(addr[1:0]),	// Cores decode two bits only
		.data_in	(data_in),
		.wd_rd_ctrl	(wd_rd_ctrl),
		.wd_wr_ctrl	(wd_wr_ctrl),
		.drive_idx	(drive_idx),
		.core_ce	(core_ce),
		.drive_rd	(drive_rd),
		.drive_wr	(drive_wr),
		.wd_access	(wd_access)
	);

	drive_mount_status u_mount
	(
		.CLK		(CLK),
		.RESET_N	(RESET_N),
		.img_mounted	(img_mounted),
		.img_readonly	(img_readonly),
		.img_size	(img_size),
		.ff40		(ff40),
		.drive_cfg	(drive_cfg)
	);

	host_response u_resp
	(
		.addr		(addr),
		.hdd_en		(hdd_en),
		.wd_rd		(wd_rd_ctrl),	// Unsynchronised, data is valid at CPU rate
		.ff40		(ff40),
		.drive_idx	(drive_idx),
		.drive_resp	(drive_resp),
		.data_hdd	(data_hdd),
		.halt		(halt),
		.nmi		(nmi),
		.sel_intrq	(sel_intrq)
	);

endmodule

// ==== fdc_pkg.sv ====
// Shared constants and bus structs for the floppy controller glue, imported by every block
package fdc_pkg;

	////////////////////////////////////////
	// Constants
	////////////////////////////////////////

	localparam int NUM_DRIVES = 4;	// One controller core per drive
	localparam int CE_DIV = 6;	// Core enable period in CLK cycles

	// Image size window for a double-sided disk, both bounds exclusive
	localparam logic [63:0] DS_MIN_BYTES = 64'd368600;
	localparam logic [63:0] DS_MAX_BYTES = 64'd740000;

	localparam logic [3:0] FF40_ADDR = 4'h0;	// Control register, offset on the bus

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [1:0] drive_idx_t;	// Selected drive, 0 to 3

	// Control register, laid out in readback order
	typedef struct packed {
		logic		halt_en;	// Bit 7, HALT on DRQ low
		logic		side_sel;	// Bit 6, drive select 3 or side select
		logic		density;	// Bit 5, also gates NMI
		logic		wrt_prec;	// Bit 4
		logic		motor;		// Bit 3
		logic [2:0]	drive_sel;	// Bits 2..0
	} ff40_reg_t;

	// Per-drive setup handed to a core
	typedef struct packed {
		logic	wp;		// Write protect
		logic	ready;		// Image present
		logic	layout;		// 0 track-side-sector, 1 side-track-sector
		logic	side;		// Head select
	} drive_cfg_t;

	// Per-drive response coming back from a core
	typedef struct packed {
		logic		drq;
		logic		intrq;
		logic [7:0]	dout;
	} drive_resp_t;

	// Latched register access, shared by all cores
	typedef struct packed {
		logic [1:0]	addr;
		logic [7:0]	data;
	} wd_access_t;

endpackage

// ==== fdc_properties.sv ====
// Bound assertions on the access stretcher, checks core enable spacing and strobe shape
`timescale 1ns/1ps

module fdc_properties
(
	input	logic				CLK,
	input	logic				RESET_N,
	input	logic				core_ce,
	input	logic [fdc_pkg::NUM_DRIVES-1:0]	drive_rd,
	input	logic [fdc_pkg::NUM_DRIVES-1:0]	drive_wr
);

	// At most one core gets a write at a time
	wr_onehot: assert property (@(posedge CLK) disable iff (!RESET_N) $onehot0(drive_wr))
		else $error("write strobe reaches more than one drive");

	// Divider gives single cycle enables
	ce_single: assert property (@(posedge CLK) disable iff (!RESET_N) core_ce |=> !core_ce)
		else $error("core enable high on two cycles in a row");

	// Everything quiet once reset has been seen
	quiet_in_reset: assert property (@(posedge CLK)
		!RESET_N |=> (drive_rd == '0) && (drive_wr == '0) && !core_ce)
		else $error("strobe or core enable high during reset");

endmodule

bind wd_access_stretch fdc_properties props0
(
	.CLK		(CLK),
	.RESET_N	(RESET_N),
	.core_ce	(core_ce),
	.drive_rd	(drive_rd),
	.drive_wr	(drive_wr)
);

// ==== ff40_ctrl_reg.sv ====
// Drive control register at FF40 with drive index decode, used by the FDC top level
`timescale 1ns/1ps

module ff40_ctrl_reg
(
	input	logic			CLK,
	input	logic			RESET_N,
	input	logic			ff40_wr,	// Write strobe for the register
	input	logic [7:0]		data_in,
	input	logic			sel_intrq,	// INTRQ of the selected core
	output	fdc_pkg::ff40_reg_t	ff40,
	output	fdc_pkg::drive_idx_t	drive_idx
);

	import fdc_pkg::*;

	drive_idx_t	idx_dec;	// Index implied by the byte being written

	////////////////////////////////////////
	// Drive index decode
	////////////////////////////////////////

	// Drive select bits are one-hot; with side select set, drives 0..2 also
	// accept select 3 alongside. Anything else keeps the current drive
	always_comb
	begin
		case ({data_in[6], data_in[2:0]})
			4'b0001, 4'b1001:
				idx_dec = 2'd0;
			4'b0010, 4'b1010:
				idx_dec = 2'd1;
			4'b0100, 4'b1100:
				idx_dec = 2'd2;
			4'b1000:
				idx_dec = 2'd3;	// Select 3 alone
			default:
				idx_dec = drive_idx;	// Illegal code
		endcase
	end

	////////////////////////////////////////
	// Register
	////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (!RESET_N)
		begin
			ff40 <= '0;
			drive_idx <= '0;
		end
		else
		begin
			if (ff40_wr)
			begin
				ff40 <= ff40_reg_t'(data_in);	// Byte maps straight onto the fields
				drive_idx <= idx_dec;
			end
			// Interrupt from the selected core drops HALT mode, wins over a write
			if (sel_intrq)
				ff40.halt_en <= 1'b0;
		end
	end

endmodule

// ==== host_response.sv ====
// Routes the selected core's response back to the CPU as read data, HALT and NMI
`timescale 1ns/1ps

module host_response
(
	input	logic			[3:0]	addr,
	input	logic				hdd_en,		// FDC register space decode
	input	logic				wd_rd,		// Raw CPU read of a core
	input	fdc_pkg::ff40_reg_t		ff40,
	input	fdc_pkg::drive_idx_t		drive_idx,
	input	fdc_pkg::drive_resp_t		drive_resp [fdc_pkg::NUM_DRIVES],
	output	logic			[7:0]	data_hdd,
	output	logic				halt,
	output	logic				nmi,
	output	logic				sel_intrq	// Back to the control register
);

	import fdc_pkg::*;

	drive_resp_t	sel_resp;	// Response of the addressed drive

	assign sel_resp = drive_resp[drive_idx];

	////////////////////////////////////////
	// CPU read data
	////////////////////////////////////////

	always_comb
	begin
		if (hdd_en && (addr == FF40_ADDR))
			data_hdd = ff40;		// Control register readback
		else if (wd_rd)
			data_hdd = sel_resp.dout;	// Core register
		else
			data_hdd = 8'h00;
	end

	////////////////////////////////////////
	// Interrupt lines
	////////////////////////////////////////

	// CPU halts until the core asks for data
	assign halt = ff40.halt_en && !sel_resp.drq;

	// NMI only in double density, ends HALT mode transfers
	assign nmi = ff40.density && sel_resp.intrq;

	assign sel_intrq = sel_resp.intrq;

endmodule

// ==== tb_fdc.sv ====
// Directed testbench for the floppy controller glue that runs as top with the bound assertions
`timescale 1ns/1ps

module tb_fdc;

	import fdc_pkg::*;

	localparam int TEST_COUNT = 16;		// Task calls made by the main sequence
	localparam int TIMEOUT_CYCLES = TEST_COUNT * 2000;
	localparam int SETTLE = 2;		// Combinational settle after a negedge drive

	logic			CLK, RESET_N;
	logic [3:0]		addr;
	logic [7:0]		data_in;
	logic			hdd_en, ff40_wr, wd_rd_ctrl, wd_wr_ctrl;
	logic [NUM_DRIVES-1:0]	img_mounted;
	logic			img_readonly;
	logic [63:0]		img_size;
	drive_resp_t		drive_resp [NUM_DRIVES];
	logic [7:0]		data_hdd;
	logic			halt, nmi, core_ce;
	logic [NUM_DRIVES-1:0]	drive_rd, drive_wr;
	wd_access_t		wd_access;
	drive_cfg_t		drive_cfg [NUM_DRIVES];
	integer			seed;

	fdc dut0 (.*);

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;	// 20 ns period
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		abort_run("watchdog timeout, the tests did not finish in time");
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_strobes(input string name, input logic [NUM_DRIVES-1:0] exp,
		input logic [NUM_DRIVES-1:0] act);
		if (act !== exp)
			abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_access(input string name, input wd_access_t exp, input wd_access_t act);
		if (act !== exp)
			abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_cfg(input string name, input drive_cfg_t exp, input drive_cfg_t act);
		if (act !== exp)
			abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
	endtask

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [NUM_DRIVES-1:0] onehot(input int k);
		return NUM_DRIVES'(1) << k;
	endfunction

	// Control byte selecting drive k; drive 3 is reached through side select alone
	function automatic logic [7:0] sel_code(input int k, input logic side,
		input logic halt_en, input logic density);
		ff40_reg_t r;
		r = '0;
		r.halt_en = halt_en;
		r.density = density;
		r.side_sel = (k == 3) ? 1'b1 : side;
		r.drive_sel = (k == 3) ? 3'b000 : 3'(1 << k);
		return r;
	endfunction

	task automatic write_ctrl(input logic [7:0] v);
		@(negedge CLK);
		data_in = v;
		ff40_wr = 1'b1;
		@(negedge CLK);
		ff40_wr = 1'b0;
	endtask

	task automatic wait_idle(input string name);
		repeat (CE_DIV + 4) @(negedge CLK);	// Sync chain and stretch both drained
		check_strobes(name, '0, drive_rd | drive_wr);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	// Core enable is a single cycle pulse once every CE_DIV cycles
	task automatic ce_period();
		int wait_n;
		wait_n = 0;
		@(negedge CLK);
		while (core_ce !== 1'b1)
		begin
			if (wait_n == CE_DIV)
				abort_run("ce_period: core enable never went high");
			wait_n++;
			@(negedge CLK);
		end
		for (int n = 1; n <= 2 * CE_DIV; n++)
		begin
			@(negedge CLK);
			check_bit($sformatf("ce_period cycle %0d", n), (n % CE_DIV) == 0, core_ce);
		end
	endtask

	task automatic ctrl_readback();
		logic [7:0] v;
		v = 8'($random(seed));
		write_ctrl(v);
		hdd_en = 1'b1;
		addr = FF40_ADDR;
		#SETTLE;
		check_byte("ctrl_readback data_hdd", v, data_hdd);
		@(negedge CLK);
		hdd_en = 1'b0;
	endtask

	// Write access to drive k, which must already be selected
	task automatic wr_strobe(input int k, input string name);
		logic [1:0]	a;
		logic [7:0]	d;
		logic		seen;
		wd_access_t	exp_acc;
		a = 2'($random(seed));
		d = 8'($random(seed));
		seen = 1'b0;
		@(negedge CLK);
		addr = {2'b00, a};
		data_in = d;
		wd_wr_ctrl = 1'b1;
		for (int n = 0; n < 3 + CE_DIV + 1; n++)	// Whole pulse inside this window
		begin
			@(negedge CLK);
			if (drive_wr != '0)
			begin
				check_strobes({name, " drive_wr"}, onehot(k), drive_wr);
				seen = 1'b1;
			end
		end
		if (!seen)
			abort_run($sformatf("%s: write strobe for drive %0d never rose", name, k));
		check_strobes({name, " drive_wr end"}, '0, drive_wr);
		exp_acc.addr = a;
		exp_acc.data = d;
		check_access({name, " wd_access"}, exp_acc, wd_access);
		wd_wr_ctrl = 1'b0;
		wait_idle({name, " idle"});
	endtask

	task automatic write_access(input int k);
		write_ctrl(sel_code(k, 1'b0, 1'b0, 1'b0));
		wr_strobe(k, $sformatf("write_access k=%0d", k));
	endtask

	// Bad select code keeps drive 2 as target
	task automatic illegal_select();
		write_ctrl(sel_code(2, 1'b0, 1'b0, 1'b0));
		write_ctrl(8'h03);
		wr_strobe(2, "illegal_select");
	endtask

	task automatic read_access(input int k);
		logic [7:0]	base;
		logic		seen;
		string		name;
		base = 8'($random(seed));
		seen = 1'b0;
		name = $sformatf("read_access k=%0d", k);
		write_ctrl(sel_code(k, 1'b0, 1'b0, 1'b0));
		for (int i = 0; i < NUM_DRIVES; i++)
			drive_resp[i].dout = base ^ 8'(8'h11 * i);	// Distinct per drive
		hdd_en = 1'b0;
		addr = 4'h1;
		wd_rd_ctrl = 1'b1;
		#SETTLE;
		check_byte({name, " data_hdd"}, drive_resp[k].dout, data_hdd);
		for (int n = 0; n < 3; n++)
		begin
			@(negedge CLK);
			if (drive_rd != '0)
				seen = 1'b1;
		end
		if (!seen)
			abort_run($sformatf("%s: read strobe for drive %0d never rose", name, k));
		check_strobes({name, " drive_rd"}, onehot(k), drive_rd);
		wd_rd_ctrl = 1'b0;
		#SETTLE;
		check_byte({name, " data_hdd off"}, 8'h00, data_hdd);
		wait_idle({name, " idle"});
	endtask

	task automatic mount_status(input int k);
		drive_cfg_t	exp;
		string		name;
		name = $sformatf("mount_status k=%0d", k);
		write_ctrl(sel_code(k, 1'b1, 1'b0, 1'b0));
		@(negedge CLK);
		img_readonly = 1'b1;
		img_size = 64'd500000;	// Inside the double-sided window
		img_mounted[k] = 1'b1;
		@(negedge CLK);
		img_mounted[k] = 1'b0;
		@(negedge CLK);
		exp = '{wp: 1'b1, ready: 1'b1, layout: (k == 3), side: (k != 3)};
		check_cfg({name, " cfg"}, exp, drive_cfg[k]);
		write_ctrl(sel_code(k, 1'b0, 1'b0, 1'b0));	// Side select off
		#SETTLE;
		exp.side = 1'b0;
		check_cfg({name, " cfg side off"}, exp, drive_cfg[k]);
	endtask

	task automatic halt_nmi();
		logic [7:0] code;
		code = sel_code(1, 1'b0, 1'b1, 1'b1);	// Drive 1, HALT mode, double density
		@(negedge CLK);
		for (int i = 0; i < NUM_DRIVES; i++)
		begin
			drive_resp[i].drq = 1'b0;
			drive_resp[i].intrq = 1'b0;
		end
		write_ctrl(code);
		#SETTLE;
		check_bit("halt_nmi halt idle", 1'b1, halt);
		check_bit("halt_nmi nmi idle", 1'b0, nmi);
		@(negedge CLK);
		drive_resp[1].drq = 1'b1;
		drive_resp[0].intrq = 1'b1;	// Unselected drive has no effect
		#SETTLE;
		check_bit("halt_nmi halt drq", 1'b0, halt);
		check_bit("halt_nmi nmi other", 1'b0, nmi);
		@(negedge CLK);
		drive_resp[1].drq = 1'b0;
		#SETTLE;
		check_bit("halt_nmi halt kept", 1'b1, halt);
		@(negedge CLK);
		drive_resp[1].intrq = 1'b1;
		#SETTLE;
		check_bit("halt_nmi nmi", 1'b1, nmi);
		@(negedge CLK);
		drive_resp[0].intrq = 1'b0;
		drive_resp[1].intrq = 1'b0;
		hdd_en = 1'b1;
		addr = FF40_ADDR;
		#SETTLE;
		check_bit("halt_nmi halt cleared", 1'b0, halt);
		check_byte("halt_nmi readback", {1'b0, code[6:0]}, data_hdd);
		@(negedge CLK);
		hdd_en = 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		seed = 32'h49ea_a976;
		RESET_N = 1'b0;
		addr = '0;
		data_in = '0;
		hdd_en = 1'b0;
		ff40_wr = 1'b0;
		wd_rd_ctrl = 1'b0;
		wd_wr_ctrl = 1'b0;
		img_mounted = '0;
		img_readonly = 1'b0;
		img_size = '0;
		for (int i = 0; i < NUM_DRIVES; i++)
			drive_resp[i] = '0;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		RESET_N = 1'b1;

		ce_period();
		ctrl_readback();
		for (int k = 0; k < NUM_DRIVES; k++)
			write_access(k);
		illegal_select();
		for (int k = 0; k < NUM_DRIVES; k++)
			read_access(k);
		for (int k = 0; k < NUM_DRIVES; k++)
			mount_status(k);
		halt_nmi();

		$display("sim passed");
		$finish;
	end

endmodule

// ==== wd_access_stretch.sv ====
// Core clock enable and CPU access synchroniser for the FDC top level that stretches strobes until a core enable is caught
`timescale 1ns/1ps

module wd_access_stretch
(
	input	logic					CLK,
	input	logic					RESET_N,
	input	logic [1:0]				addr,		// Register select for the cores
	input	logic [7:0]				data_in,
	input	logic					wd_rd_ctrl,	// CPU read, asynchronous
	input	logic					wd_wr_ctrl,	// CPU write, asynchronous
	input	fdc_pkg::drive_idx_t			drive_idx,
	output	logic					core_ce,
	output	logic [fdc_pkg::NUM_DRIVES-1:0]		drive_rd,
	output	logic [fdc_pkg::NUM_DRIVES-1:0]		drive_wr,
	output	fdc_pkg::wd_access_t			wd_access
);

	import fdc_pkg::*;

	localparam int CE_W = $clog2(CE_DIV);

	logic [CE_W-1:0]	div_cnt;
	logic			rd_s1, rd_s2, rd_d;	// Read sync stages and edge delay
	logic			wr_s1, wr_s2, wr_d;	// Write sync stages and edge delay
	logic			active;			// A strobe is being stretched
	logic			ce_found;		// Core enable seen while active
	logic [NUM_DRIVES-1:0]	rd_e;			// Stretched read strobes
	logic [NUM_DRIVES-1:0]	sel_oh;			// One-hot of the selected drive

	////////////////////////////////////////
	// Core clock enable
	////////////////////////////////////////

	assign core_ce = (div_cnt == CE_W'(CE_DIV - 1));

	always_ff @(posedge CLK)
	begin
		if (!RESET_N)
			div_cnt <= '0;
		else if (core_ce)
			div_cnt <= '0;	// Wrap
		else
			div_cnt <= div_cnt + 1'b1;
	end

	////////////////////////////////////////
	// Access latch
	////////////////////////////////////////

	// Captured as the first sync stage rises, while the CPU still holds the bus
	always_ff @(posedge CLK)
	begin
		if (!RESET_N)
			wd_access <= '0;
		else if ((rd_s1 && !rd_s2) || (wr_s1 && !wr_s2))
		begin
			wd_access.addr <= addr;
			wd_access.data <= data_in;
		end
	end

	////////////////////////////////////////
	// Sync and stretch
	////////////////////////////////////////

	assign sel_oh = NUM_DRIVES'(1) << drive_idx;

	// Read level passes straight on while the stretch only guarantees a core enable
	assign drive_rd = (rd_e | {NUM_DRIVES{rd_s2}}) & sel_oh;

	always_ff @(posedge CLK)
	begin
		if (!RESET_N)
		begin
			rd_s1 <= 1'b0;
			rd_s2 <= 1'b0;
			rd_d <= 1'b0;
			wr_s1 <= 1'b0;
			wr_s2 <= 1'b0;
			wr_d <= 1'b0;
			active <= 1'b0;
			ce_found <= 1'b0;
			rd_e <= '0;
			drive_wr <= '0;
		end
		else
		begin
			rd_s1 <= wd_rd_ctrl;
			rd_s2 <= rd_s1;
			rd_d <= rd_s2;
			wr_s1 <= wd_wr_ctrl;
			wr_s2 <= wr_s1;
			wr_d <= wr_s2;

			if (wr_s2 && !wr_d)	// Write rising edge
			begin
				active <= 1'b1;
				drive_wr <= sel_oh;
			end
			if (rd_s2 && !rd_d)	// Read rising edge
			begin
				active <= 1'b1;
				rd_e <= sel_oh;
			end

			if (core_ce && active)
				ce_found <= 1'b1;

			// One cycle after the enable, drop everything
			if (ce_found)
			begin
				ce_found <= 1'b0;
				active <= 1'b0;
				rd_e <= '0;
				drive_wr <= '0;
			end
		end
	end

endmodule
